// File: src/exec_pkg.sv
/*
 * Execution unit package
 * Data, operation, carry source, width and flag types shared by the
 * ALU, flag register, register bank and command sequencer.
 */
package exec_pkg;

    typedef logic [31:0] word_t;       // register and operand word
    typedef logic [3:0]  alu_sel_t;    // ALU operation code
    typedef logic [2:0]  carry_sel_t;  // carry source select
    typedef logic [2:0]  width_t;      // one-hot operand width
    typedef logic [5:0]  flags_t;      // S Z H V N C
    typedef logic [2:0]  reg_addr_t;   // register index

    localparam alu_sel_t ADD_ALU  = 4'd0;
    localparam alu_sel_t SUB_ALU  = 4'd1;
    localparam alu_sel_t DAA_ALU  = 4'd2;
    localparam alu_sel_t BAND_ALU = 4'd3;
    localparam alu_sel_t BOR_ALU  = 4'd4;
    localparam alu_sel_t BXOR_ALU = 4'd5;
    localparam alu_sel_t OR_ALU   = 4'd6;
    localparam alu_sel_t XOR_ALU  = 4'd7;
    localparam alu_sel_t AND_ALU  = 4'd8;
    localparam alu_sel_t CPL_ALU  = 4'd9;
    localparam alu_sel_t MIRR_ALU = 4'd10;
    localparam alu_sel_t BS1B_ALU = 4'd11;
    localparam alu_sel_t MOD_ALU  = 4'd12;

    localparam carry_sel_t ZERO_CARRY = 3'd0;
    localparam carry_sel_t CIN_CARRY  = 3'd1;  // flag C
    localparam carry_sel_t COM_CARRY  = 3'd2;  // inverted flag C
    localparam carry_sel_t B0_CARRY   = 3'd3;  // op0 bit 0
    localparam carry_sel_t HI_CARRY   = 3'd4;
    localparam carry_sel_t ZF_CARRY   = 3'd5;  // flag Z

    localparam width_t W_BYTE = 3'b001;
    localparam width_t W_WORD = 3'b010;
    localparam width_t W_LONG = 3'b100;

    // bit positions inside flags_t
    localparam int FLAG_S = 5;
    localparam int FLAG_Z = 4;
    localparam int FLAG_H = 3;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    typedef enum logic [1:0] {
        IDLE,
        OPERAND,
        EXECUTE
    } seq_state_e;

endpackage

// File: src/alu_bus_if.sv
/*
 * ALU bus
 * Operands and controls from the sequencer to the ALU, and the
 * result and flags coming back.
 */
`timescale 1ns/1ps

interface alu_bus_if;
    import exec_pkg::*;

    word_t      op0;        // destination operand
    word_t      op1;        // source operand
    word_t      op2;        // merge value
    alu_sel_t   alu_sel;
    carry_sel_t carry_sel;
    width_t     w;
    word_t      rslt;
    flags_t     flags_out;

    modport seq (
        output op0, op1, op2,
        output alu_sel, carry_sel, w
    );

    modport alu (
        input  op0, op1, op2,
        input  alu_sel, carry_sel, w,
        output rslt, flags_out
    );

endinterface

// File: src/alu_core.sv
/*
 * Execution ALU
 * Combinational unit for add, subtract, decimal adjust, bit, logic,
 * complement, mirror, bit search and merge operations at byte, word
 * or long width, with S, Z, H, V and C outputs.
 */
`timescale 1ns/1ps

module alu_core (
    alu_bus_if.alu          bus,
    input exec_pkg::flags_t flags_in
);
    import exec_pkg::*;

    word_t      a;
    word_t      b;
    word_t      bx;          // op1, inverted for subtract
    word_t      sum;
    word_t      wmask;       // bits of the selected width
    word_t      rslt;
    logic       is_sub;
    logic       cx;
    logic       cin0;
    logic       half;
    logic [2:0] cc;          // carries out of byte, word and long
    logic       cw;          // carry at selected width
    logic [4:0] msb;
    logic       h_out;
    logic       v_out;
    logic       c_out;
    logic [7:0] daa_corr;
    logic       daa_c;
    logic [3:0] bidx;
    logic       bsel;
    logic       bit_out;
    logic [3:0] top_idx;

    assign a      = bus.op0;
    assign b      = bus.op1;
    assign is_sub = (bus.alu_sel == SUB_ALU);
    assign bidx   = b[3:0];
    assign bsel   = a[bidx];

    always_comb begin
        case (bus.carry_sel)
            CIN_CARRY: cx = flags_in[FLAG_C];
            COM_CARRY: cx = ~flags_in[FLAG_C];
            B0_CARRY:  cx = a[0];
            HI_CARRY:  cx = 1'b1;
            ZF_CARRY:  cx = flags_in[FLAG_Z];
            default:   cx = 1'b0;
        endcase
    end

    // subtract runs as a + ~b + ~borrow, so carries come out inverted
    assign bx   = is_sub ? ~b : b;
    assign cin0 = is_sub ? ~cx : cx;

    always_comb begin
        {half,  sum[3:0]}   = {1'b0, a[3:0]}   + {1'b0, bx[3:0]}   + {4'd0, cin0};
        {cc[0], sum[7:4]}   = {1'b0, a[7:4]}   + {1'b0, bx[7:4]}   + {4'd0, half};
        {cc[1], sum[15:8]}  = {1'b0, a[15:8]}  + {1'b0, bx[15:8]}  + {8'd0, cc[0]};
        {cc[2], sum[31:16]} = {1'b0, a[31:16]} + {1'b0, bx[31:16]} + {16'd0, cc[1]};
    end

    always_comb begin
        case (bus.w)
            W_BYTE: begin
                wmask = 32'h0000_00ff;
                msb   = 5'd7;
                cw    = cc[0];
            end
            W_WORD: begin
                wmask = 32'h0000_ffff;
                msb   = 5'd15;
                cw    = cc[1];
            end
            default: begin
                wmask = 32'hffff_ffff;
                msb   = 5'd31;
                cw    = cc[2];
            end
        endcase
    end

    // decimal adjust correction
    always_comb begin
        daa_corr[3:0] = (flags_in[FLAG_H] || a[3:0] > 4'd9) ? 4'd6 : 4'd0;
        daa_corr[7:4] = (flags_in[FLAG_C] || a[7:0] > 8'h99) ? 4'd6 : 4'd0;
        daa_c         = flags_in[FLAG_C] || (a[7:0] > 8'h99);
    end

    always_comb begin
        top_idx = 4'd0;
        for (int i = 0; i < 16; i++) begin
            if (a[i]) top_idx = 4'(i);  // last hit is the highest bit
        end
    end

    always_comb begin
        case (bus.alu_sel)
            BAND_ALU: bit_out = bsel & cx;
            BOR_ALU:  bit_out = bsel | cx;
            default:  bit_out = bsel ^ cx;
        endcase
    end

    always_comb begin
        rslt  = a;
        h_out = 1'b0;
        v_out = 1'b0;
        c_out = 1'b0;
        case (bus.alu_sel)
            ADD_ALU, SUB_ALU: begin
                rslt  = (a & ~wmask) | (sum & wmask);
                h_out = half ^ is_sub;
                c_out = cw ^ is_sub;
                v_out = (a[msb] == bx[msb]) && (sum[msb] != a[msb]);
            end
            DAA_ALU: begin
                rslt[7:0] = flags_in[FLAG_N] ? a[7:0] - daa_corr : a[7:0] + daa_corr;
                c_out     = daa_c;
            end
            BAND_ALU, BOR_ALU, BXOR_ALU: begin
                rslt[bidx] = bit_out;
                c_out      = bit_out;
            end
            OR_ALU:  rslt = a | b;
            XOR_ALU: rslt = a ^ b;
            AND_ALU: rslt = a & b;
            CPL_ALU: rslt[15:0] = ~a[15:0];
            MIRR_ALU: begin
                for (int i = 0; i < 16; i++) begin
                    rslt[i] = a[15-i];
                end
            end
            BS1B_ALU: begin
                rslt[7:0] = {4'd0, top_idx};
                v_out     = (a[15:0] == 16'd0);  // no bit set
            end
            MOD_ALU: rslt = (a & ~b) | (bus.op2 & b);
            default: ;
        endcase
    end

    assign bus.rslt      = rslt;
    assign bus.flags_out = {rslt[msb], (rslt & wmask) == 32'd0, h_out, v_out,
                            flags_in[FLAG_N], c_out};

endmodule

// File: src/flag_reg.sv
/*
 * Status flag register
 * Writes the subset of ALU flags that each operation owns. A second
 * copy feeds the ALU and holds across the update, so the result stays
 * steady while done is high.
 */
`timescale 1ns/1ps

module flag_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                cen,
    input  logic                update,
    input  exec_pkg::alu_sel_t  alu_sel,
    input  exec_pkg::flags_t    flags_out,
    output exec_pkg::flags_t    flags,
    output exec_pkg::flags_t    flags_alu
);
    import exec_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            flags     <= '0;
            flags_alu <= '0;
        end else if (cen) begin
            if (update) begin
                case (alu_sel)
                    ADD_ALU, SUB_ALU: begin
                        flags         <= flags_out;
                        flags[FLAG_N] <= (alu_sel == SUB_ALU);
                    end
                    OR_ALU, XOR_ALU, AND_ALU: begin
                        flags[FLAG_S] <= flags_out[FLAG_S];
                        flags[FLAG_Z] <= flags_out[FLAG_Z];
                        flags[FLAG_H] <= (alu_sel == AND_ALU);
                        flags[FLAG_V] <= 1'b0;
                        flags[FLAG_N] <= 1'b0;
                        flags[FLAG_C] <= 1'b0;
                    end
                    BAND_ALU, BOR_ALU, BXOR_ALU: flags[FLAG_C] <= flags_out[FLAG_C];
                    DAA_ALU: begin
                        flags[FLAG_S] <= flags_out[FLAG_S];
                        flags[FLAG_Z] <= flags_out[FLAG_Z];
                        flags[FLAG_C] <= flags_out[FLAG_C];
                    end
                    CPL_ALU: begin
                        flags[FLAG_H] <= 1'b1;
                        flags[FLAG_N] <= 1'b1;
                    end
                    BS1B_ALU: flags[FLAG_V] <= flags_out[FLAG_V];
                    default: ;  // MIRR and MOD keep flags
                endcase
            end else begin
                flags_alu <= flags;  // frozen during update
            end
        end
    end

endmodule

// File: src/reg_bank.sv
/*
 * Register bank
 * General registers with two asynchronous read ports, a write-back
 * port and an external load port that wins on a shared address.
 */
`timescale 1ns/1ps

module reg_bank #(
    parameter int NUM_REGS = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  exec_pkg::reg_addr_t rd_addr0,
    input  exec_pkg::reg_addr_t rd_addr1,
    output exec_pkg::word_t     rd_data0,
    output exec_pkg::word_t     rd_data1,
    input  logic                wr_en,
    input  exec_pkg::reg_addr_t wr_addr,
    input  exec_pkg::word_t     wr_data,
    input  logic                load,
    input  exec_pkg::reg_addr_t load_addr,
    input  exec_pkg::word_t     load_data
);
    import exec_pkg::*;

    word_t regs [NUM_REGS];

    assign rd_data0 = regs[rd_addr0];
    assign rd_data1 = regs[rd_addr1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                regs[wr_addr] <= wr_data;
            end
            if (load) begin
                regs[load_addr] <= load_data;  // last write wins
            end
        end
    end

endmodule

// File: src/exec_seq.sv
/*
 * Command sequencer
 * Accepts one command per start, registers operands onto the ALU bus,
 * then writes back, updates flags and pulses done.
 */
`timescale 1ns/1ps

module exec_seq (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cen,
    input  logic                  start,
    input  exec_pkg::alu_sel_t    alu_sel,
    input  exec_pkg::carry_sel_t  carry_sel,
    input  exec_pkg::width_t      w,
    input  exec_pkg::reg_addr_t   dst,
    input  exec_pkg::reg_addr_t   src,
    input  logic                  use_imm,
    input  exec_pkg::word_t       imm,
    output exec_pkg::reg_addr_t   rd_addr0,
    output exec_pkg::reg_addr_t   rd_addr1,
    input  exec_pkg::word_t       rd_data0,
    input  exec_pkg::word_t       rd_data1,
    alu_bus_if.seq                bus,
    output logic                  wr_en,
    output exec_pkg::reg_addr_t   wr_addr,
    output logic                  flag_update,
    output logic                  busy,
    output logic                  done
);
    import exec_pkg::*;

    seq_state_e state;
    reg_addr_t  dst_q;
    reg_addr_t  src_q;
    logic       use_imm_q;
    logic       accept;

    assign accept = (state == IDLE) && start;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            done  <= 1'b0;
        end else if (cen) begin
            done <= (state == EXECUTE);
            case (state)
                IDLE:    if (start) state <= OPERAND;
                OPERAND: state <= EXECUTE;
                default: state <= IDLE;
            endcase
        end
    end

    // command latch and operand capture
    always_ff @(posedge clk) begin
        if (cen) begin
            if (accept) begin
                bus.alu_sel   <= alu_sel;
                bus.carry_sel <= carry_sel;
                bus.w         <= w;
                bus.op2       <= imm;
                dst_q         <= dst;
                src_q         <= src;
                use_imm_q     <= use_imm;
            end
            if (state == OPERAND) begin
                bus.op0 <= rd_data0;
                bus.op1 <= use_imm_q ? bus.op2 : rd_data1;
            end
        end
    end

    assign rd_addr0    = dst_q;
    assign rd_addr1    = src_q;
    assign wr_addr     = dst_q;
    assign wr_en       = (state == EXECUTE) && cen;  // bank has no enable
    assign flag_update = (state == EXECUTE);
    assign busy        = (state != IDLE);

endmodule

// File: src/exec_unit.sv
/*
 * Execution unit top
 * Sequencer, register bank, ALU and flag register tied together.
 */
`timescale 1ns/1ps

module exec_unit #(
    parameter int NUM_REGS = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cen,
    input  logic                  start,
    input  exec_pkg::alu_sel_t    alu_sel,
    input  exec_pkg::carry_sel_t  carry_sel,
    input  exec_pkg::width_t      w,
    input  exec_pkg::reg_addr_t   dst,
    input  exec_pkg::reg_addr_t   src,
    input  logic                  use_imm,
    input  exec_pkg::word_t       imm,
    input  logic                  load,
    input  exec_pkg::reg_addr_t   load_addr,
    input  exec_pkg::word_t       load_data,
    output logic                  busy,
    output logic                  done,
    output exec_pkg::word_t       rslt,
    output exec_pkg::flags_t      flags
);
    import exec_pkg::*;

    reg_addr_t rd_addr0;
    reg_addr_t rd_addr1;
    word_t     rd_data0;
    word_t     rd_data1;
    reg_addr_t wr_addr;
    flags_t    flags_alu;
    logic      wr_en;
    logic      flag_update;

    alu_bus_if bus ();

    exec_seq u_seq (
        .clk         (clk),
        .reset       (reset),
        .cen         (cen),
        .start       (start),
        .alu_sel     (alu_sel),
        .carry_sel   (carry_sel),
        .w           (w),
        .dst         (dst),
        .src         (src),
        .use_imm     (use_imm),
        .imm         (imm),
        .rd_addr0    (rd_addr0),
        .rd_addr1    (rd_addr1),
        .rd_data0    (rd_data0),
        .rd_data1    (rd_data1),
        .bus         (bus),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .flag_update (flag_update),
        .busy        (busy),
        .done        (done)
    );

    reg_bank #(
        .NUM_REGS (NUM_REGS)
    ) u_regs (
        .clk       (clk),
        .reset     (reset),
        .rd_addr0  (rd_addr0),
        .rd_addr1  (rd_addr1),
        .rd_data0  (rd_data0),
        .rd_data1  (rd_data1),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (bus.rslt),
        .load      (load),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    alu_core u_alu (
        .bus      (bus),
        .flags_in (flags_alu)
    );

    flag_reg u_flags (
        .clk       (clk),
        .reset     (reset),
        .cen       (cen),
        .update    (flag_update),
        .alu_sel   (bus.alu_sel),
        .flags_out (bus.flags_out),
        .flags     (flags),
        .flags_alu (flags_alu)
    );

    assign rslt = bus.rslt;

endmodule

// File: bench/exec_tb_cases.svh
/*
 * Execution unit test table
 * One command per row with hand-worked results. Rows run in order,
 * so the flags of one row feed the carry and DAA of the next.
 */

// columns: dst value, src value, load dst, op, carry, width, use imm, imm,
//          cen stall, expected rslt, expected flags (S Z H V N C)
task automatic build_cases();
    // add and subtract, upper bits kept at narrow widths
    add_case('h123456F0, 'h20, 1, ADD_ALU, ZERO_CARRY, W_BYTE, 0, 0, 0, 'h12345610, 6'b000001);
    add_case('hABCD7FFF, 0, 1, ADD_ALU, CIN_CARRY, W_WORD, 0, 0, 1, 'hABCD8000, 6'b101100);
    add_case('h10, 'h11, 1, SUB_ALU, ZERO_CARRY, W_LONG, 0, 0, 0, 'hFFFFFFFF, 6'b101011);
    add_case('hFFFFFFFF, 'h1, 1, ADD_ALU, ZERO_CARRY, W_LONG, 0, 0, 0, 0, 6'b011001);
    add_case('h11110005, 'h3, 1, SUB_ALU, CIN_CARRY, W_WORD, 0, 0, 0, 'h11110001, 6'b000010);
    add_case('h55555580, 'h1, 1, SUB_ALU, COM_CARRY, W_BYTE, 0, 0, 1, 'h5555557E, 6'b001110);
    // logic and merge
    add_case('hF0F00000, 'hF0F0000, 1, OR_ALU, ZERO_CARRY, W_LONG, 0, 0, 0, 'hFFFF0000, 6'b100000);
    add_case('h12345678, 'hFF, 1, XOR_ALU, ZERO_CARRY, W_LONG, 1, 'h12345678, 0, 0, 6'b010000);
    add_case('h800000FF, 'hFF, 1, AND_ALU, ZERO_CARRY, W_LONG, 1, 'h8000000F,
             1, 'h8000000F, 6'b101000);
    add_case('hAAAAAAAA, 'hFF00, 1, MOD_ALU, ZERO_CARRY, W_LONG, 0, 'h12345678,
             0, 'hAAAA56AA, 6'b101000);
    // single bit operations
    add_case('h8, 0, 1, BAND_ALU, HI_CARRY, W_LONG, 1, 'h3, 0, 'h8, 6'b101001);
    add_case('h1, 0, 1, BOR_ALU, B0_CARRY, W_LONG, 1, 'h7, 0, 'h81, 6'b101001);
    add_case('h8000, 0, 1, BXOR_ALU, HI_CARRY, W_LONG, 1, 'hF, 0, 0, 6'b101000);
    add_case(0, 'hFFFFFFFC, 1, BOR_ALU, HI_CARRY, W_LONG, 0, 0, 1, 'h1000, 6'b101001);
    // decimal adjust on the previous result
    add_case('h19, 'h28, 1, ADD_ALU, ZERO_CARRY, W_BYTE, 0, 0, 0, 'h41, 6'b001000);
    add_case(0, 0, 0, DAA_ALU, ZERO_CARRY, W_BYTE, 0, 0, 0, 'h47, 6'b001000);
    add_case('h99, 'h1, 1, ADD_ALU, ZERO_CARRY, W_BYTE, 0, 0, 0, 'h9A, 6'b100000);
    add_case(0, 0, 0, DAA_ALU, ZERO_CARRY, W_BYTE, 0, 0, 1, 0, 6'b010001);
    add_case('h42, 'h15, 1, SUB_ALU, ZERO_CARRY, W_BYTE, 0, 0, 0, 'h2D, 6'b001010);
    add_case(0, 0, 0, DAA_ALU, ZERO_CARRY, W_BYTE, 0, 0, 0, 'h27, 6'b001010);
    add_case('h15, 'h20, 1, SUB_ALU, ZERO_CARRY, W_BYTE, 0, 0, 0, 'hF5, 6'b100011);
    add_case(0, 0, 0, DAA_ALU, ZERO_CARRY, W_BYTE, 0, 0, 0, 'h95, 6'b100011);
    // complement, mirror, bit search, with read-back of dst
    add_case('h123400FF, 0, 1, CPL_ALU, ZERO_CARRY, W_WORD, 0, 0, 0, 'h1234FF00, 6'b101011);
    add_case(0, 0, 0, OR_ALU, ZERO_CARRY, W_LONG, 1, 0, 0, 'h1234FF00, 6'b000000);
    add_case('hABCD0001, 0, 1, MIRR_ALU, ZERO_CARRY, W_WORD, 0, 0, 0, 'hABCD8000, 6'b000000);
    add_case('h240, 0, 1, BS1B_ALU, ZERO_CARRY, W_WORD, 0, 0, 0, 'h209, 6'b000000);
    add_case(0, 0, 0, OR_ALU, ZERO_CARRY, W_LONG, 1, 0, 0, 'h209, 6'b000000);
    add_case('hFFFF0000, 0, 1, BS1B_ALU, ZERO_CARRY, W_WORD, 0, 0, 0, 'hFFFF0000, 6'b000100);
endtask

// File: bench/exec_tb.sv
/*
 * Execution unit testbench
 * Loads registers, issues each table command and checks the result,
 * the flags, busy and done timing of the execution unit.
 */
`timescale 1ns/1ps

module exec_tb;
    import exec_pkg::*;

    localparam reg_addr_t DST_REG = 3'd1;
    localparam reg_addr_t SRC_REG = 3'd2;
    localparam int        LIMIT   = 100;  // cycles to wait for done

    typedef struct packed {
        word_t      dst_val;
        word_t      src_val;
        logic       load_dst;   // reload dst before the command
        alu_sel_t   op;
        carry_sel_t cs;
        width_t     w;
        logic       use_imm;
        word_t      imm;
        logic       stall;      // random cen stalls
        word_t      exp_rslt;
        flags_t     exp_flags;
    } case_t;

    logic       clk;
    logic       reset;
    logic       cen;
    logic       start;
    alu_sel_t   alu_sel;
    carry_sel_t carry_sel;
    width_t     w;
    reg_addr_t  dst;
    reg_addr_t  src;
    logic       use_imm;
    word_t      imm;
    logic       load;
    reg_addr_t  load_addr;
    word_t      load_data;
    logic       busy;
    logic       done;
    word_t      rslt;
    flags_t     flags;

    case_t cases[$];
    int    errors;
    int    passed;
    int    failed;

    exec_unit #(.NUM_REGS(8)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_case(input word_t dv, input word_t sv, input int ld,
                            input alu_sel_t op, input carry_sel_t cs, input width_t wd,
                            input int ui, input word_t iv, input int st,
                            input word_t er, input flags_t ef);
        case_t c;
        c.dst_val   = dv;
        c.src_val   = sv;
        c.load_dst  = (ld != 0);
        c.op        = op;
        c.cs        = cs;
        c.w         = wd;
        c.use_imm   = (ui != 0);
        c.imm       = iv;
        c.stall     = (st != 0);
        c.exp_rslt  = er;
        c.exp_flags = ef;
        cases.push_back(c);
    endtask

    `include "exec_tb_cases.svh"

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int first_err);
        if (errors == first_err) begin
            passed++;
            $display("%s ok", name);
        end else begin
            failed++;
            $display("%s FAILED", name);
        end
    endtask

    task automatic run_case(input int idx);
        case_t c;
        int    first_err;
        int    cycles;
        int    waited;
        int    extra;
        c         = cases[idx];
        first_err = errors;
        @(negedge clk);
        load      = 1'b1;
        load_addr = SRC_REG;
        load_data = c.src_val;
        if (c.load_dst) begin
            @(negedge clk);
            load_addr = DST_REG;
            load_data = c.dst_val;
        end
        @(negedge clk);
        load      = 1'b0;
        alu_sel   = c.op;
        carry_sel = c.cs;
        w         = c.w;
        use_imm   = c.use_imm;
        imm       = c.imm;
        cen       = 1'b1;
        start     = 1'b1;  // accepted on the next edge
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        waited = 0;
        while (!done && waited < LIMIT) begin
            if (c.stall) cen = ($urandom % 3) != 0;
            start = busy && (($urandom % 4) == 0);  // must be ignored
            @(negedge clk);
            if (cen) cycles++;
            waited++;
            if (!done && !busy) begin
                $display("case %0d: busy dropped before done", idx);
                errors++;
            end
        end
        start = 1'b0;
        cen   = 1'b1;
        if (!done) begin
            $display("case %0d: done never came within %0d cycles", idx, LIMIT);
            errors++;
        end else begin
            check("rslt", rslt, c.exp_rslt);
            check("flags", word_t'(flags), word_t'(c.exp_flags));
            check("enabled cycles to done", cycles, 2);
            check("busy with done", word_t'(busy), 0);
        end
        extra = 0;
        repeat (4) begin
            @(negedge clk);
            if (done) extra++;
        end
        if (extra != 0) begin
            $display("case %0d: done stayed high or came a second time", idx);
            errors++;
        end
        report($sformatf("case %0d", idx), first_err);
    endtask

    initial begin
        void'($urandom(4310));
        reset     = 1'b1;
        cen       = 1'b1;
        start     = 1'b0;
        alu_sel   = ADD_ALU;
        carry_sel = ZERO_CARRY;
        w         = W_LONG;
        dst       = DST_REG;
        src       = SRC_REG;
        use_imm   = 1'b0;
        imm       = '0;
        load      = 1'b0;
        load_addr = '0;
        load_data = '0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        build_cases();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        check("busy after reset", word_t'(busy), 0);
        check("done after reset", word_t'(done), 0);
        check("flags after reset", word_t'(flags), 0);
        report("reset", 0);
        for (int i = 0; i < cases.size(); i++) begin
            run_case(i);
        end
        $display("passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: exec_unit.f
+incdir+bench
src/exec_pkg.sv
src/alu_bus_if.sv
src/alu_core.sv
src/flag_reg.sv
src/reg_bank.sv
src/exec_seq.sv
src/exec_unit.sv
bench/exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execution unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f exec_unit.f --top-module exec_tb -Mdir obj_dir || exit 1
out=$(./obj_dir/Vexec_tb)
echo "$out"
echo "$out" | grep -q "Test passed" && exit 0 || exit 1
